// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_digital_clock
FLIST     ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/tb_digital_clock.sv ====
`timescale 1ns/1ps

module tb_digital_clock;

	localparam int TICK_DIV = 400;
	localparam int SCAN_DIV = 4;
	localparam int BTN_DIV  = 8;
	localparam int DAY_SEC  = 86400;

	localparam int M_CLOCK = 0;
	localparam int M_SETUP = 1;
	localparam int M_ALARM = 2;
	localparam int M_WORLD = 3;

	localparam int B_MODE  = 0;
	localparam int B_POS   = 1;
	localparam int B_ADJ   = 2;
	localparam int B_ALARM = 3;
	localparam int B_ZONE  = 4;

	logic       clk;
	logic       rst_n;
	logic [4:0] btn_n;	// Active low, indexed by B_*
	logic [6:0] o_seg;
	logic [5:0] o_seg_enb;
	logic       o_seg_dp;
	logic       o_alarm;

	int cyc = 0;
	int tick_num = 0;
	int frame_cnt = 0;
	int val_errs = 0;
	int proto_errs = 0;
	int t_now = 0;	// Model time of day in seconds
	int t_alarm = 0;
	int m_mode = M_CLOCK;
	int m_zone = 0;
	int zone_ofs [3] = '{14, 9, 2};
	int frm [6];
	int dp_frm [6];
	logic [5:0] seen;

	digital_clock #(
		.TICK_DIV (TICK_DIV),
		.SCAN_DIV (SCAN_DIV),
		.BTN_DIV  (BTN_DIV)
	) i_dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (btn_n[B_MODE]),
		.i_btn_pos   (btn_n[B_POS]),
		.i_btn_adj   (btn_n[B_ADJ]),
		.i_btn_alarm (btn_n[B_ALARM]),
		.i_btn_zone  (btn_n[B_ZONE]),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb),
		.o_seg_dp    (o_seg_dp),
		.o_alarm     (o_alarm)
	);

	always #50 clk = ~clk;

	// ------------------------------
	// Reference model and capture
	// ------------------------------
	always @(posedge clk) begin
		if (rst_n) begin
			if (cyc % TICK_DIV == 0 && cyc != 0) begin	// Time updates one cycle after tick
				tick_num = tick_num + 1;
				if (m_mode != M_SETUP)
					t_now = (t_now + 1) % DAY_SEC;
			end
			cyc = cyc + 1;
		end
	end

	function automatic int seg_to_num(input logic [6:0] s);
		case (s)
			7'b111_1110: return 0;
			7'b011_0000: return 1;
			7'b110_1101: return 2;
			7'b111_1001: return 3;
			7'b011_0011: return 4;
			7'b101_1011: return 5;
			7'b101_1111: return 6;
			7'b111_0000: return 7;
			7'b111_1111: return 8;
			7'b111_0011: return 9;
			default:     return 15;	// Not a digit
		endcase
	endfunction

	always @(negedge clk) begin
		if (!rst_n) begin
			seen = '0;
		end else begin
			for (int i = 0; i < 6; i++) begin
				if (!o_seg_enb[i]) begin
					if (o_seg != 7'b000_0000)	// Blanked digit keeps old value
						frm[i] = seg_to_num(o_seg);
					dp_frm[i] = int'(o_seg_dp);
					seen[i] = 1'b1;
				end
			end
			if (seen == 6'h3F) begin
				frame_cnt = frame_cnt + 1;
				seen = '0;
			end
		end
	end

	a_enb_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~o_seg_enb))
		else begin
			proto_errs++;
			$display("At %0t o_seg_enb does not have exactly one low bit", $time);
		end

	a_enb_walk: assert property (@(posedge clk) disable iff (!rst_n)
		(o_seg_enb != $past(o_seg_enb)) |->
		(o_seg_enb == {$past(o_seg_enb[4:0]), $past(o_seg_enb[5])}))
		else begin
			proto_errs++;
			$display("At %0t o_seg_enb skipped a digit in the scan order", $time);
		end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic timeout_fail(input string what);
		$display("Timeout while waiting for %s", what);
		$display("sim failed");
		$finish;
	endtask

	task automatic check_val(input string name, input int exp, input int got);
		assert (exp == got)
		else begin
			val_errs++;
			$display("ERR %0t %s expected %0d actual %0d", $time, name, exp, got);
		end
	endtask

	task automatic check_frame(input int t);
		int exp [6];
		exp[0] = (t % 60) % 10;
		exp[1] = (t % 60) / 10;
		exp[2] = ((t / 60) % 60) % 10;
		exp[3] = ((t / 60) % 60) / 10;
		exp[4] = (t / 3600) % 10;
		exp[5] = (t / 3600) / 10;
		for (int i = 0; i < 6; i++)
			check_val($sformatf("o_seg digit %0d", i), exp[i], frm[i]);
	endtask

	task automatic check_dp(input int on_idx);	// -1 means all off
		for (int i = 0; i < 6; i++)
			check_val($sformatf("o_seg_dp digit %0d", i), int'(i == on_idx), dp_frm[i]);
	endtask

	task automatic wait_frame();
		int start;
		int n;
		start = frame_cnt;
		n = 0;
		while (frame_cnt < start + 2) begin	// Second frame is fully fresh
			@(negedge clk);
			n++;
			if (n > 200)
				timeout_fail("a display frame");
		end
	endtask

	task automatic wait_tick();
		int start;
		int n;
		start = tick_num;
		n = 0;
		while (tick_num == start) begin
			@(negedge clk);
			n++;
			if (n > 2 * TICK_DIV)
				timeout_fail("a seconds tick");
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic wait_visible();
		int n;
		n = 0;
		while (tick_num % 2 != 0) begin	// Blink starts visible, toggles per tick
			wait_tick();
			n++;
			if (n > 3)
				timeout_fail("the visible blink phase");
		end
	endtask

	task automatic press_button(input int idx, input int n);
		repeat (n) begin
			btn_n[idx] = 1'b0;
			repeat (3 * BTN_DIV) @(negedge clk);
			btn_n[idx] = 1'b1;
			repeat (3 * BTN_DIV) @(negedge clk);
		end
	endtask

	function automatic int add_field(input int t, input int p, input int n);
		int h;
		int m;
		int s;
		h = t / 3600;
		m = (t / 60) % 60;
		s = t % 60;
		case (p)
			0:       s = (s + n) % 60;
			1:       m = (m + n) % 60;
			default: h = (h + n) % 24;
		endcase
		return h * 3600 + m * 60 + s;
	endfunction

	// ------------------------------
	// Stimulus
	// ------------------------------
	initial begin
		int n;
		int tw;
		void'($urandom(18859));
		clk = 1'b0;
		rst_n = 1'b0;
		btn_n = '1;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;

		repeat (3) begin
			wait_frame();
			check_frame(0);
			check_dp(-1);
			check_val("o_alarm", 0, int'(o_alarm));
		end

		repeat (130) begin
			wait_tick();
			wait_frame();
			check_frame(t_now);
			check_dp(-1);
		end

		wait_tick();
		press_button(B_MODE, 1);
		m_mode = M_SETUP;
		for (int p = 0; p < 3; p++) begin
			n = $urandom_range(20, 70);
			press_button(B_ADJ, n);
			t_now = add_field(t_now, p, n);
			wait_visible();
			wait_frame();
			check_frame(t_now);	// Also proves frozen time
			check_dp(2 * p);
			press_button(B_POS, 1);
		end

		wait_tick();
		press_button(B_MODE, 1);
		m_mode = M_ALARM;
		t_alarm = (t_now + 90) % DAY_SEC;	// Far enough ahead to finish setup
		press_button(B_ADJ, t_alarm % 60);
		press_button(B_POS, 1);
		press_button(B_ADJ, (t_alarm / 60) % 60);
		press_button(B_POS, 1);
		press_button(B_ADJ, t_alarm / 3600);
		press_button(B_POS, 1);
		wait_visible();
		wait_frame();
		check_frame(t_alarm);
		check_dp(1);
		press_button(B_ALARM, 1);

		wait_tick();
		press_button(B_MODE, 1);
		m_mode = M_WORLD;
		for (int z = 0; z < 4; z++) begin
			wait_tick();
			if (z > 0) begin
				press_button(B_ZONE, 1);
				m_zone = (m_zone + 1) % 3;
			end
			wait_frame();
			tw = ((t_now / 3600 + zone_ofs[m_zone]) % 24) * 3600 + t_now % 3600;
			check_frame(tw);
			check_dp(-1);
		end

		wait_tick();
		press_button(B_MODE, 1);
		m_mode = M_CLOCK;
		n = 0;
		while (t_now != t_alarm) begin
			check_val("o_alarm", 0, int'(o_alarm));
			wait_tick();
			n++;
			if (n > 200)
				timeout_fail("the alarm time");
		end
		check_val("o_alarm", 1, int'(o_alarm));
		repeat (2) begin
			wait_tick();
			check_val("o_alarm", 1, int'(o_alarm));	// Latched past the match
		end
		press_button(B_ALARM, 1);
		check_val("o_alarm", 0, int'(o_alarm));

		$display("Errors: value %0d, protocol %0d", val_errs, proto_errs);
		if (val_errs == 0 && proto_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== sources.f ====
src/clock_pkg.sv
src/clock_ctrl_if.sv
src/clock_ctrl.sv
src/time_keeper.sv
src/seg_scan.sv
src/digital_clock.sv
bench/tb_digital_clock.sv

// ==== src/clock_ctrl.sv ====
`timescale 1ns/1ps

module clock_ctrl import clock_pkg::*; #(
	parameter int TICK_DIV = 50_000_000,
	parameter int BTN_DIV  = 500_000
) (
	input logic        clk,
	input logic        rst_n,
	input logic        i_btn_mode,
	input logic        i_btn_pos,
	input logic        i_btn_adj,
	input logic        i_btn_alarm,
	input logic        i_btn_zone,
	clock_ctrl_if.ctrl o_ctrl
);

	localparam int BTN_CW  = $clog2(BTN_DIV + 1);
	localparam int TICK_CW = $clog2(TICK_DIV + 1);
	localparam int NUM_BTN = 5;

	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_ADJ   = 2;
	localparam int BTN_ALARM = 3;
	localparam int BTN_ZONE  = 4;

	logic [BTN_CW-1:0]  smp_cnt;
	logic               smp_stb;
	logic               smp_dly;	// Marks cycle after a fresh sample
	logic [NUM_BTN-1:0] btn_raw;
	logic [NUM_BTN-1:0] btn_cur;
	logic [NUM_BTN-1:0] btn_prv;
	logic [NUM_BTN-1:0] press;
	logic [TICK_CW-1:0] tick_cnt;
	logic               tick_q;
	mode_t              mode_q;
	pos_t               pos_q;
	zone_t              zone_q;
	logic               alarm_en_q;

	// ------------------------------
	// Button sampling
	// ------------------------------
	assign btn_raw = {i_btn_zone, i_btn_alarm, i_btn_adj, i_btn_pos, i_btn_mode};
	assign smp_stb = (smp_cnt == BTN_CW'(BTN_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp_cnt <= '0;
			smp_dly <= 1'b0;
			btn_cur <= '1;	// Released
			btn_prv <= '1;
		end else begin
			smp_dly <= smp_stb;
			if (smp_stb) begin
				smp_cnt <= '0;
				btn_cur <= btn_raw;
				btn_prv <= btn_cur;
			end else begin
				smp_cnt <= smp_cnt + 1'b1;
			end
		end
	end

	// High then low across two samples
	assign press = {NUM_BTN{smp_dly}} & btn_prv & ~btn_cur;

	// ------------------------------
	// Control registers
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q     <= MODE_CLOCK;
			pos_q      <= POS_SEC;
			zone_q     <= ZONE_USA;
			alarm_en_q <= 1'b0;
		end else begin
			if (press[BTN_MODE])
				mode_q <= mode_t'(mode_q + 2'd1);	// Four modes wrap by width
			if (press[BTN_POS])
				pos_q <= (pos_q == POS_HOU) ? POS_SEC : pos_t'(pos_q + 2'd1);
			if (press[BTN_ZONE])
				zone_q <= (zone_q == ZONE_AUS) ? ZONE_USA : zone_t'(zone_q + 2'd1);
			if (press[BTN_ALARM])
				alarm_en_q <= ~alarm_en_q;
		end
	end

	// Seconds prescaler
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			tick_q   <= 1'b0;
		end else if (tick_cnt == TICK_CW'(TICK_DIV - 1)) begin
			tick_cnt <= '0;
			tick_q   <= 1'b1;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
			tick_q   <= 1'b0;
		end
	end

	assign o_ctrl.mode     = mode_q;
	assign o_ctrl.pos      = pos_q;
	assign o_ctrl.zone     = zone_q;
	assign o_ctrl.alarm_en = alarm_en_q;
	assign o_ctrl.tick     = tick_q;
	assign o_ctrl.adj      = press[BTN_ADJ] && (mode_q == MODE_SETUP || mode_q == MODE_ALARM);

	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
		o_ctrl.tick |=> !o_ctrl.tick);

	a_adj_mode: assert property (@(posedge clk) disable iff (!rst_n)
		o_ctrl.adj |-> (o_ctrl.mode inside {MODE_SETUP, MODE_ALARM}));

endmodule

// ==== src/clock_ctrl_if.sv ====
`timescale 1ns/1ps

interface clock_ctrl_if import clock_pkg::*; ();

	mode_t mode;
	pos_t  pos;
	zone_t zone;
	logic  alarm_en;
	logic  tick;	// One cycle per second
	logic  adj;	// One cycle per adjust press, edit modes only

	modport ctrl (
		output mode,
		output pos,
		output zone,
		output alarm_en,
		output tick,
		output adj
	);

	modport keep (
		input tick,
		input adj,
		input mode,
		input pos,
		input zone,
		input alarm_en
	);

	modport disp (input tick, input mode, input pos);

endinterface

// ==== src/clock_pkg.sv ====
package clock_pkg;

	// ------------------------------
	// Mode, field and zone selects
	// ------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK,	// Running time of day
		MODE_SETUP,	// Time frozen, fields adjustable
		MODE_ALARM,	// Alarm time shown and adjustable
		MODE_WORLD	// Hour shifted by zone offset
	} mode_t;

	typedef enum logic [1:0] {
		POS_SEC,
		POS_MIN,
		POS_HOU
	} pos_t;

	typedef enum logic [1:0] {
		ZONE_USA,
		ZONE_ENG,
		ZONE_AUS
	} zone_t;

	typedef struct packed {
		logic [5:0] hou;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	typedef logic [6:0] seg_t;	// {a, b, c, d, e, f, g}, active high

	// ------------------------------
	// Limits and constants
	// ------------------------------
	localparam logic [5:0] SEC_MAX = 6'd59;
	localparam logic [5:0] MIN_MAX = 6'd59;
	localparam logic [5:0] HOU_MAX = 6'd23;

	localparam logic [5:0] ZONE_OFS_USA = 6'd14;
	localparam logic [5:0] ZONE_OFS_ENG = 6'd9;
	localparam logic [5:0] ZONE_OFS_AUS = 6'd2;

	localparam int NUM_DIGITS = 6;
	localparam seg_t SEG_BLANK = 7'b000_0000;

endpackage

// ==== src/digital_clock.sv ====
`timescale 1ns/1ps

module digital_clock import clock_pkg::*; #(
	parameter int TICK_DIV = 50_000_000,	// Cycles per second
	parameter int SCAN_DIV = 5_000,	// Cycles per digit
	parameter int BTN_DIV  = 500_000	// Cycles per button sample
) (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   i_btn_mode,
	input logic                   i_btn_pos,
	input logic                   i_btn_adj,
	input logic                   i_btn_alarm,
	input logic                   i_btn_zone,
	output seg_t                  o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_seg_dp,
	output logic                  o_alarm
);

	hms_t disp_time;

	clock_ctrl_if u_ctrl_if ();

	clock_ctrl #(
		.TICK_DIV (TICK_DIV),
		.BTN_DIV  (BTN_DIV)
	) u_clock_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (i_btn_mode),
		.i_btn_pos   (i_btn_pos),
		.i_btn_adj   (i_btn_adj),
		.i_btn_alarm (i_btn_alarm),
		.i_btn_zone  (i_btn_zone),
		.o_ctrl      (u_ctrl_if.ctrl)
	);

	time_keeper u_time_keeper (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_ctrl      (u_ctrl_if.keep),
		.o_disp_time (disp_time),
		.o_alarm     (o_alarm)
	);

	seg_scan #(
		.SCAN_DIV (SCAN_DIV)
	) u_seg_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_ctrl      (u_ctrl_if.disp),
		.i_disp_time (disp_time),
		.o_seg       (o_seg),
		.o_seg_enb   (o_seg_enb),
		.o_seg_dp    (o_seg_dp)
	);

endmodule

// ==== src/seg_scan.sv ====
`timescale 1ns/1ps

module seg_scan import clock_pkg::*; #(
	parameter int SCAN_DIV = 5_000
) (
	input logic                   clk,
	input logic                   rst_n,
	clock_ctrl_if.disp            i_ctrl,
	input hms_t                   i_disp_time,
	output seg_t                  o_seg,
	output logic [NUM_DIGITS-1:0] o_seg_enb,
	output logic                  o_seg_dp
);

	localparam int SCAN_CW = $clog2(SCAN_DIV + 1);

	logic [SCAN_CW-1:0] scan_cnt;
	logic [2:0]         dig_sel;	// 0 is seconds ones, 5 hours tens
	logic               blink;
	logic [3:0]         digit [NUM_DIGITS];
	logic [3:0]         dig_val;
	logic               edit_mode;
	logic               in_field;

	function automatic seg_t seg_dec(input logic [3:0] num);
		case (num)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return SEG_BLANK;
		endcase
	endfunction

	// ------------------------------
	// Digit split
	// ------------------------------
	always_comb begin
		digit[0] = 4'(i_disp_time.sec % 6'd10);
		digit[1] = 4'(i_disp_time.sec / 6'd10);
		digit[2] = 4'(i_disp_time.min % 6'd10);
		digit[3] = 4'(i_disp_time.min / 6'd10);
		digit[4] = 4'(i_disp_time.hou % 6'd10);
		digit[5] = 4'(i_disp_time.hou / 6'd10);
	end

	// ------------------------------
	// Scan and blink
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt <= '0;
			dig_sel  <= 3'd0;
		end else if (scan_cnt == SCAN_CW'(SCAN_DIV - 1)) begin
			scan_cnt <= '0;
			dig_sel  <= (dig_sel == 3'(NUM_DIGITS - 1)) ? 3'd0 : dig_sel + 3'd1;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			blink <= 1'b1;	// Start in the visible phase
		else if (i_ctrl.tick)
			blink <= ~blink;
	end

	assign dig_val   = digit[dig_sel];
	assign edit_mode = (i_ctrl.mode == MODE_SETUP) || (i_ctrl.mode == MODE_ALARM);
	assign in_field  = (dig_sel[2:1] == i_ctrl.pos);	// Digit pair of the selected field

	assign o_seg     = (edit_mode && in_field && !blink) ? SEG_BLANK : seg_dec(dig_val);
	assign o_seg_enb = ~(NUM_DIGITS'(1) << dig_sel);

	// Ones digit in setup, tens digit in alarm
	always_comb begin
		case (i_ctrl.mode)
			MODE_SETUP: o_seg_dp = in_field && !dig_sel[0];
			MODE_ALARM: o_seg_dp = in_field && dig_sel[0];
			default:    o_seg_dp = 1'b0;
		endcase
	end

	a_one_enb: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~o_seg_enb));

endmodule

// ==== src/time_keeper.sv ====
`timescale 1ns/1ps

module time_keeper import clock_pkg::*; (
	input logic        clk,
	input logic        rst_n,
	clock_ctrl_if.keep i_ctrl,
	output hms_t       o_disp_time,
	output logic       o_alarm
);

	hms_t       tod_q;	// Time of day
	hms_t       alm_q;	// Alarm time
	logic       alarm_q;
	logic       match;
	logic [5:0] zone_ofs;
	logic [5:0] world_sum;
	logic [5:0] world_hou;

	function automatic logic [5:0] wrap_inc(input logic [5:0] val, input logic [5:0] lim);
		return (val >= lim) ? 6'd0 : val + 6'd1;
	endfunction

	// Single field step, no carry into the next field
	function automatic hms_t adj_field(input hms_t t, input pos_t p);
		hms_t r;
		r = t;
		case (p)
			POS_SEC: r.sec = wrap_inc(t.sec, SEC_MAX);
			POS_MIN: r.min = wrap_inc(t.min, MIN_MAX);
			POS_HOU: r.hou = wrap_inc(t.hou, HOU_MAX);
			default: r = t;
		endcase
		return r;
	endfunction

	// ------------------------------
	// Time of day
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tod_q <= '0;
		end else if (i_ctrl.mode == MODE_SETUP) begin
			if (i_ctrl.adj)	// Frozen apart from edits
				tod_q <= adj_field(tod_q, i_ctrl.pos);
		end else if (i_ctrl.tick) begin
			tod_q.sec <= wrap_inc(tod_q.sec, SEC_MAX);
			if (tod_q.sec == SEC_MAX) begin
				tod_q.min <= wrap_inc(tod_q.min, MIN_MAX);
				if (tod_q.min == MIN_MAX)
					tod_q.hou <= wrap_inc(tod_q.hou, HOU_MAX);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			alm_q <= '0;
		else if (i_ctrl.adj && i_ctrl.mode == MODE_ALARM)
			alm_q <= adj_field(alm_q, i_ctrl.pos);
	end

	// Latched until the alarm is disabled
	assign match = (tod_q == alm_q);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			alarm_q <= 1'b0;
		else
			alarm_q <= i_ctrl.alarm_en & (alarm_q | match);
	end

	assign o_alarm = alarm_q;

	// ------------------------------
	// Display selection
	// ------------------------------
	always_comb begin
		case (i_ctrl.zone)
			ZONE_ENG: zone_ofs = ZONE_OFS_ENG;
			ZONE_AUS: zone_ofs = ZONE_OFS_AUS;
			default:  zone_ofs = ZONE_OFS_USA;
		endcase
	end

	assign world_sum = tod_q.hou + zone_ofs;	// At most 37, fits six bits
	assign world_hou = (world_sum > HOU_MAX) ? world_sum - (HOU_MAX + 6'd1) : world_sum;

	always_comb begin
		case (i_ctrl.mode)
			MODE_ALARM: o_disp_time = alm_q;
			MODE_WORLD: o_disp_time = '{hou: world_hou, min: tod_q.min, sec: tod_q.sec};
			default:    o_disp_time = tod_q;
		endcase
	end

	a_field_range: assert property (@(posedge clk) disable iff (!rst_n)
		tod_q.sec <= SEC_MAX && tod_q.min <= MIN_MAX && tod_q.hou <= HOU_MAX &&
		alm_q.sec <= SEC_MAX && alm_q.min <= MIN_MAX && alm_q.hou <= HOU_MAX &&
		o_disp_time.hou <= HOU_MAX);

endmodule
